// File: all.f
source/pr_pkg.sv
source/pr_fifo.sv
source/pr_ctrl_regs.sv
source/pr_fetch.sv
source/pr_accum.sv
source/pr_div.sv
source/pr_writeback.sv
source/pagerank_top.sv
dv/pagerank_assert.sv
dv/pr_mem_model.sv
dv/tb_pagerank.sv

// File: dv/pagerank_assert.sv
module pagerank_assert (
	input logic clk,
	input logic rst,
	input logic sr_valid,
	input pr_pkg::sr_req_t sr_req,
	input logic sr_resp_valid,
	input logic ar_valid,
	input pr_pkg::mem_ar_t ar,
	input logic ar_ready,
	input logic aw_valid,
	input logic aw_ready
);

	// number of failed assertions so far
	int fail_cnt = 0;

	// read request must not move while it waits for ar_ready
	ar_hold_stable: assert property (@(posedge clk) disable iff (rst)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
	else begin
		fail_cnt++;
		$error("ar dropped or changed before ar_ready");
	end

	aw_hold_valid: assert property (@(posedge clk) disable iff (rst)
		aw_valid && !aw_ready |=> aw_valid)
	else begin
		fail_cnt++;
		$error("aw_valid dropped before aw_ready");
	end

	// soft-register response comes exactly one cycle after a read
	sr_resp_follows_read: assert property (@(posedge clk) disable iff (rst)
		sr_valid && !sr_req.is_write |=> sr_resp_valid)
	else begin
		fail_cnt++;
		$error("no sr_resp_valid one cycle after a register read");
	end

	sr_resp_only_after_read: assert property (@(posedge clk) disable iff (rst)
		!(sr_valid && !sr_req.is_write) |=> !sr_resp_valid)
	else begin
		fail_cnt++;
		$error("sr_resp_valid without a register read the cycle before");
	end

endmodule

bind pagerank_top pagerank_assert i_pagerank_assert (
	.clk(clk),
	.rst(rst),
	.sr_valid(sr_valid),
	.sr_req(sr_req),
	.sr_resp_valid(sr_resp_valid),
	.ar_valid(ar_valid),
	.ar(ar),
	.ar_ready(ar_ready),
	.aw_valid(aw_valid),
	.aw_ready(aw_ready)
);

// File: dv/pr_mem_model.sv
module pr_mem_model (
	input logic clk,
	input logic random_en,
	input logic ar_valid,
	input pr_pkg::mem_ar_t ar,
	output logic ar_ready,
	output logic r_valid,
	output pr_pkg::mem_r_t r,
	input logic r_ready,
	input logic aw_valid,
	input pr_pkg::mem_aw_t aw,
	output logic aw_ready,
	input logic w_valid,
	input logic [63:0] w_data,
	output logic w_ready,
	output logic b_valid,
	input logic b_ready
);

	// 1024 words of 8 bytes, indexed by address bits 12:3
	logic [63:0] mem [1024];
	logic [31:0] rng;
	logic ar_seen;
	logic aw_seen;
	logic w_seen;
	logic r_taken;
	logic b_taken;
	pr_pkg::mem_ar_t ar_hold;
	pr_pkg::mem_ar_t rd_req;
	logic [63:0] aw_hold;
	logic [63:0] w_hold;
	logic rd_pend;
	logic [1:0] rd_wait;
	logic have_aw;
	logic have_w;
	logic [63:0] wr_addr;
	logic [63:0] wr_word;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// graph loader and result readback, no simulation time used
	task automatic load_word(input logic [63:0] addr, input logic [63:0] data);
		mem[addr[12:3]] = data;
	endtask

	function automatic logic [63:0] peek_word(input logic [63:0] addr);
		return mem[addr[12:3]];
	endfunction

	initial begin
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r = '0;
		aw_ready = 1'b0;
		w_ready = 1'b0;
		b_valid = 1'b0;
		rng = 32'hd571;
		ar_seen = 1'b0;
		aw_seen = 1'b0;
		w_seen = 1'b0;
		r_taken = 1'b0;
		b_taken = 1'b0;
		rd_pend = 1'b0;
		rd_wait = '0;
		have_aw = 1'b0;
		have_w = 1'b0;
		// every word starts as a pattern of its own index
		for (int i = 0; i < 1024; i++)
			mem[i] = {~32'(i), 32'(i)};
		forever begin
			@(posedge clk);
			#1;
			// responses accepted at the edge just passed
			if (r_valid && r_taken)
				r_valid = 1'b0;
			if (b_valid && b_taken)
				b_valid = 1'b0;
			// handshakes completed at the edge just passed
			if (ar_seen && ar_ready) begin
				rd_pend = 1'b1;
				rd_req = ar_hold;
				rd_wait = random_en ? rng[9:8] : 2'd0;
			end
			if (aw_seen && aw_ready) begin
				have_aw = 1'b1;
				wr_addr = aw_hold;
			end
			if (w_seen && w_ready) begin
				have_w = 1'b1;
				wr_word = w_hold;
			end
			// read data after the latency drawn at the request
			if (rd_pend && !r_valid) begin
				if (rd_wait == 0) begin
					r_valid = 1'b1;
					r.id = rd_req.id;
					r.data.raw = mem[rd_req.addr[12:3]];
					rd_pend = 1'b0;
				end else begin
					rd_wait = rd_wait - 2'd1;
				end
			end
			// write lands once both address and data are in
			if (have_aw && have_w && !b_valid) begin
				mem[wr_addr[12:3]] = wr_word;
				b_valid = 1'b1;
				have_aw = 1'b0;
				have_w = 1'b0;
			end
			rng = xorshift(rng);
			ar_ready = ar_valid && (!random_en || rng[1:0] == 2'b00);
			aw_ready = aw_valid && !have_aw && (!random_en || rng[3:2] == 2'b00);
			w_ready = w_valid && !have_w && (!random_en || rng[5:4] == 2'b00);
			// what the DUT presents for the coming edge
			ar_seen = ar_valid;
			ar_hold = ar;
			aw_seen = aw_valid;
			aw_hold = aw.addr;
			w_seen = w_valid;
			w_hold = w_data;
			r_taken = r_ready;
			b_taken = b_ready;
		end
	end

endmodule

// File: dv/tb_pagerank.sv
module tb_pagerank;

	logic clk;
	logic rst;
	logic sr_valid;
	pr_pkg::sr_req_t sr_req;
	logic sr_resp_valid;
	logic [63:0] sr_resp_data;
	logic ar_valid;
	pr_pkg::mem_ar_t ar;
	logic ar_ready;
	logic r_valid;
	pr_pkg::mem_r_t r;
	logic r_ready;
	logic aw_valid;
	pr_pkg::mem_aw_t aw;
	logic aw_ready;
	logic w_valid;
	logic [63:0] w_data;
	logic w_ready;
	logic b_valid;
	logic b_ready;
	logic random_en;

	// memory map of the test graph
	logic [63:0] vert_base = 64'h0000;
	logic [63:0] ie_base = 64'h0400;
	logic [63:0] score_a = 64'h0800;
	logic [63:0] score_b = 64'h0c00;

	// six vertices, in-edge sources grouped by destination vertex
	// vertex 4 has no in-edges, vertex 5 has no out-edges
	int n_vert = 6;
	int n_inedges = 9;
	int in_deg [6] = '{2, 2, 2, 1, 0, 2};
	int out_deg [6] = '{2, 2, 2, 2, 1, 0};
	int edge_src [9] = '{2, 3, 0, 4, 0, 1, 2, 1, 3};

	logic [63:0] ref_score [6];
	logic [63:0] round2_score [6];
	int errors;
	int checks;
	int timeouts;

	pagerank_top i_pagerank_top (.*);

	pr_mem_model i_mem_model (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_word(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_score(input string name, input pr_pkg::mem_word_u got,
		input pr_pkg::mem_word_u exp);
		checks++;
		if (got.raw !== exp.raw) begin
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got.raw, exp.raw);
			errors++;
		end
	endtask

	// all bus tasks start and end just after a rising edge
	task automatic sr_write(input logic [31:0] addr, input logic [63:0] data);
		sr_valid = 1'b1;
		sr_req = '{is_write: 1'b1, addr: addr, data: data};
		@(posedge clk);
		#1;
		sr_valid = 1'b0;
	endtask

	task automatic sr_read(input logic [31:0] addr, output logic [63:0] data);
		sr_valid = 1'b1;
		sr_req = '{is_write: 1'b0, addr: addr, data: 64'd0};
		@(posedge clk);
		#1;
		sr_valid = 1'b0;
		if (sr_resp_valid !== 1'b1) begin
			$display("t=%0t read of register %h got no response one cycle later", $time, addr);
			errors++;
		end
		data = sr_resp_data;
	endtask

	task automatic wait_done(output bit ok);
		logic [63:0] val;
		int polls;
		ok = 1'b0;
		polls = 0;
		while (!ok && polls < 20000) begin
			sr_read(pr_pkg::reg_done, val);
			ok = (val === 64'd1);
			polls++;
		end
		if (!ok) begin
			$display("t=%0t timed out, the run never reported done", $time);
			timeouts++;
		end
	endtask

	task automatic load_graph();
		pr_pkg::vert_rec_t rec;
		for (int v = 0; v < n_vert; v++) begin
			rec.in_deg = 32'(in_deg[v]);
			rec.out_deg = 32'(out_deg[v]);
			i_mem_model.load_word(vert_base + 64'(8 * v), rec);
		end
		for (int e = 0; e < n_inedges; e++)
			i_mem_model.load_word(ie_base + 64'(8 * e), 64'(edge_src[e]));
	endtask

	// stale score words get a per-address pattern so unwritten ones show
	task automatic scrub_scores();
		logic [63:0] addr;
		for (int v = 0; v < n_vert; v++) begin
			addr = score_a + 64'(8 * v);
			i_mem_model.load_word(addr, ~addr);
			addr = score_b + 64'(8 * v);
			i_mem_model.load_word(addr, ~addr);
		end
	endtask

	task automatic run_rounds(input int rounds, output bit ok);
		load_graph();
		scrub_scores();
		sr_write(pr_pkg::reg_n_vert, 64'(n_vert));
		sr_write(pr_pkg::reg_n_inedges, 64'(n_inedges));
		sr_write(pr_pkg::reg_vert_base, vert_base);
		sr_write(pr_pkg::reg_ie_base, ie_base);
		sr_write(pr_pkg::reg_score_a, score_a);
		sr_write(pr_pkg::reg_score_b, score_b);
		sr_write(pr_pkg::reg_n_rounds, 64'(rounds));
		sr_write(pr_pkg::reg_start, 64'd1);
		wait_done(ok);
	endtask

	// new score = sum of old source scores / own out-degree
	// round 1 uses 1.0 in 16-bit fixed point over the vertex count
	task automatic ref_round(input bit first);
		logic [63:0] old_s [6];
		logic [63:0] sum;
		int e;
		e = 0;
		for (int v = 0; v < n_vert; v++)
			old_s[v] = first ? (64'd1 << 16) / 64'(n_vert) : ref_score[v];
		for (int v = 0; v < n_vert; v++) begin
			sum = '0;
			for (int k = 0; k < in_deg[v]; k++) begin
				sum = sum + old_s[edge_src[e]];
				e++;
			end
			ref_score[v] = (out_deg[v] == 0) ? 64'd0 : sum / 64'(out_deg[v]);
		end
	endtask

	task automatic check_buffer(input string name, input logic [63:0] base,
		input logic [63:0] exp [6]);
		for (int v = 0; v < n_vert; v++)
			check_score($sformatf("%s[%0d]", name, v),
				i_mem_model.peek_word(base + 64'(8 * v)), exp[v]);
	endtask

	task automatic test_reg_readback();
		logic [31:0] addrs [7] = '{pr_pkg::reg_n_vert, pr_pkg::reg_n_inedges,
			pr_pkg::reg_vert_base, pr_pkg::reg_ie_base, pr_pkg::reg_score_a,
			pr_pkg::reg_score_b, pr_pkg::reg_n_rounds};
		logic [63:0] vals [7] = '{64'h1_2345, 64'h777, 64'h1111_2222_3333_4440,
			64'h5555_6666_7777_8880, 64'h9999_aaaa_bbbb_ccc0,
			64'hdddd_eeee_ffff_0008, 64'd5};
		logic [63:0] val;
		// each read comes right after its write
		for (int i = 0; i < 7; i++) begin
			sr_write(addrs[i], vals[i]);
			sr_read(addrs[i], val);
			check_word($sformatf("register %h", addrs[i]), val, vals[i]);
		end
		// every register still holds its own value once all are written
		for (int i = 0; i < 7; i++) begin
			sr_read(addrs[i], val);
			check_word($sformatf("register %h after all writes", addrs[i]), val, vals[i]);
		end
		sr_read(32'h50, val);
		check_word("unmapped register 50", val, 64'd0);
		sr_read(32'h100, val);
		check_word("unmapped register 100", val, 64'd0);
	endtask

	task automatic test_single_round();
		bit ok;
		run_rounds(1, ok);
		if (ok) begin
			ref_round(1'b1);
			check_buffer("score_b round 1", score_b, ref_score);
		end
	endtask

	// both zero cases give a zero score by the update rule
	task automatic test_zero_degree();
		check_score("score_b[4] no in-edges",
			i_mem_model.peek_word(score_b + 64'd32), 64'd0);
		check_score("score_b[5] zero out-degree",
			i_mem_model.peek_word(score_b + 64'd40), 64'd0);
	endtask

	task automatic run_three_and_check(input string tag);
		bit ok;
		run_rounds(3, ok);
		if (ok) begin
			ref_round(1'b1);
			ref_round(1'b0);
			round2_score = ref_score;
			ref_round(1'b0);
			// round 2 landed in A, round 3 over round 1 in B
			check_buffer({tag, " score_a round 2"}, score_a, round2_score);
			check_buffer({tag, " score_b round 3"}, score_b, ref_score);
		end
	endtask

	task automatic test_three_rounds();
		random_en = 1'b0;
		run_three_and_check("fixed");
	endtask

	task automatic test_random_delays();
		random_en = 1'b1;
		run_three_and_check("random");
	endtask

	// follows a three-round run
	task automatic test_done_status();
		logic [63:0] val;
		bit ok;
		sr_read(pr_pkg::reg_done, val);
		check_word("reg_done after run", val, 64'd1);
		sr_read(pr_pkg::reg_round, val);
		check_word("reg_round after run", val, 64'd3);
		sr_write(pr_pkg::reg_start, 64'd1);
		sr_read(pr_pkg::reg_done, val);
		check_word("reg_done after restart", val, 64'd0);
		wait_done(ok);
		if (ok) begin
			sr_read(pr_pkg::reg_round, val);
			check_word("reg_round after second run", val, 64'd3);
		end
	endtask

	initial begin
		rst = 1'b1;
		sr_valid = 1'b0;
		sr_req = '0;
		random_en = 1'b0;
		errors = 0;
		checks = 0;
		timeouts = 0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		test_reg_readback();
		// a timeout leaves the engine busy, so later tests are skipped
		if (timeouts == 0)
			test_single_round();
		if (timeouts == 0)
			test_zero_degree();
		if (timeouts == 0)
			test_three_rounds();
		if (timeouts == 0)
			test_random_delays();
		if (timeouts == 0)
			test_done_status();
		$display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, i_pagerank_top.i_pagerank_assert.fail_cnt);
		if (errors == 0 && timeouts == 0 && i_pagerank_top.i_pagerank_assert.fail_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: source/pagerank_top.sv
module pagerank_top (
	input logic clk,
	input logic rst,
	input logic sr_valid,
	input pr_pkg::sr_req_t sr_req,
	output logic sr_resp_valid,
	output logic [63:0] sr_resp_data,
	output logic ar_valid,
	output pr_pkg::mem_ar_t ar,
	input logic ar_ready,
	input logic r_valid,
	input pr_pkg::mem_r_t r,
	output logic r_ready,
	output logic aw_valid,
	output pr_pkg::mem_aw_t aw,
	input logic aw_ready,
	output logic w_valid,
	output logic [63:0] w_data,
	input logic w_ready,
	input logic b_valid,
	output logic b_ready
);

	pr_pkg::round_cfg_t round_cfg;
	logic round_start;
	logic round_done;
	logic vert_valid;
	pr_pkg::vert_rec_t vert;
	logic vert_ready;
	logic score_valid;
	logic [63:0] score;
	logic score_ready;
	logic job_valid;
	pr_pkg::div_job_t job;
	logic job_ready;
	logic res_valid;
	pr_pkg::div_res_t res;
	logic res_ready;

	pr_ctrl_regs i_ctrl_regs (
		.clk(clk), .rst(rst),
		.sr_valid(sr_valid), .sr_req(sr_req),
		.sr_resp_valid(sr_resp_valid), .sr_resp_data(sr_resp_data),
		.round_done(round_done), .round_cfg(round_cfg), .round_start(round_start)
	);

	pr_fetch i_fetch (
		.clk(clk), .rst(rst),
		.round_cfg(round_cfg), .round_start(round_start),
		.ar_valid(ar_valid), .ar(ar), .ar_ready(ar_ready),
		.r_valid(r_valid), .r(r), .r_ready(r_ready),
		.vert_valid(vert_valid), .vert(vert), .vert_ready(vert_ready),
		.score_valid(score_valid), .score(score), .score_ready(score_ready)
	);

	pr_accum i_accum (
		.clk(clk), .rst(rst),
		.round_cfg(round_cfg), .round_start(round_start),
		.vert_valid(vert_valid), .vert(vert), .vert_ready(vert_ready),
		.score_valid(score_valid), .score(score), .score_ready(score_ready),
		.job_valid(job_valid), .job(job), .job_ready(job_ready),
		.res_valid(res_valid), .res(res)
	);

	// results fan out to the accumulator and the writeback
	pr_div i_div (
		.clk(clk), .rst(rst),
		.job_valid(job_valid), .job(job), .job_ready(job_ready),
		.res_valid(res_valid), .res(res), .res_ready(res_ready)
	);

	pr_writeback i_writeback (
		.clk(clk), .rst(rst),
		.round_cfg(round_cfg), .round_start(round_start),
		.res_valid(res_valid), .res(res), .res_ready(res_ready),
		.aw_valid(aw_valid), .aw(aw), .aw_ready(aw_ready),
		.w_valid(w_valid), .w_data(w_data), .w_ready(w_ready),
		.b_valid(b_valid), .b_ready(b_ready), .round_done(round_done)
	);

endmodule

// File: source/pr_accum.sv
module pr_accum (
	input logic clk,
	input logic rst,
	input pr_pkg::round_cfg_t round_cfg,
	input logic round_start,
	input logic vert_valid,
	input pr_pkg::vert_rec_t vert,
	output logic vert_ready,
	input logic score_valid,
	input logic [63:0] score,
	output logic score_ready,
	output logic job_valid,
	output pr_pkg::div_job_t job,
	input logic job_ready,
	input logic res_valid,
	input pr_pkg::div_res_t res
);

	logic [2:0] state;
	logic [31:0] in_left;
	logic [31:0] out_deg;
	logic [63:0] sum;
	logic [63:0] init_val;

	assign vert_ready = (state == pr_pkg::acc_vert) && vert_valid;
	// scores from memory are only used after round 1
	assign score_ready = (state == pr_pkg::acc_sum) && !round_cfg.first && (in_left != 0)
		&& score_valid;

	always_comb begin
		job_valid = (state == pr_pkg::acc_init_issue) || (state == pr_pkg::acc_issue);
		job.is_init = (state == pr_pkg::acc_init_issue);
		// init job is 1.0 in fixed point over the vertex count
		job.dividend = job.is_init ? (64'd1 << pr_pkg::prec) : sum;
		job.divisor = job.is_init ? round_cfg.n_vert : out_deg;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= pr_pkg::acc_idle;
		end else if (round_start) begin
			state <= round_cfg.first ? pr_pkg::acc_init_issue : pr_pkg::acc_vert;
		end else begin
			case (state)
				pr_pkg::acc_init_issue: if (job_ready) state <= pr_pkg::acc_init_wait;
				pr_pkg::acc_init_wait: if (res_valid && res.is_init) state <= pr_pkg::acc_vert;
				pr_pkg::acc_vert: if (vert_valid) state <= pr_pkg::acc_sum;
				pr_pkg::acc_sum: if (in_left == 0) state <= pr_pkg::acc_issue;
				pr_pkg::acc_issue: if (job_ready) state <= pr_pkg::acc_vert;
				default: state <= pr_pkg::acc_idle;
			endcase
		end
	end

	// running sum, one in-edge per cycle at most
	always_ff @(posedge clk) begin
		if (vert_ready) begin
			in_left <= vert.in_deg;
			out_deg <= vert.out_deg;
			sum <= '0;
		end else if (state == pr_pkg::acc_sum && in_left != 0) begin
			if (round_cfg.first) begin
				sum <= sum + init_val;
				in_left <= in_left - 32'd1;
			end else if (score_valid) begin
				sum <= sum + score;
				in_left <= in_left - 32'd1;
			end
		end
		if (res_valid && res.is_init)
			init_val <= res.quotient;
	end

endmodule

// File: source/pr_ctrl_regs.sv
module pr_ctrl_regs (
	input logic clk,
	input logic rst,
	input logic sr_valid,
	input pr_pkg::sr_req_t sr_req,
	output logic sr_resp_valid,
	output logic [63:0] sr_resp_data,
	input logic round_done,
	output pr_pkg::round_cfg_t round_cfg,
	output logic round_start
);

	logic [31:0] n_vert;
	logic [31:0] n_inedges;
	logic [63:0] vert_base;
	logic [63:0] ie_base;
	logic [63:0] score_a;
	logic [63:0] score_b;
	logic [31:0] n_rounds;
	logic [31:0] round_cnt;
	logic done;
	logic swap;
	logic start_wr;

	assign start_wr = sr_valid && sr_req.is_write && (sr_req.addr == pr_pkg::reg_start);

	// graph parameters, written by the host before start
	always_ff @(posedge clk) begin
		if (sr_valid && sr_req.is_write) begin
			case (sr_req.addr)
				pr_pkg::reg_n_vert: n_vert <= sr_req.data[31:0];
				pr_pkg::reg_n_inedges: n_inedges <= sr_req.data[31:0];
				pr_pkg::reg_vert_base: vert_base <= sr_req.data;
				pr_pkg::reg_ie_base: ie_base <= sr_req.data;
				pr_pkg::reg_score_a: score_a <= sr_req.data;
				pr_pkg::reg_score_b: score_b <= sr_req.data;
				pr_pkg::reg_n_rounds: n_rounds <= sr_req.data[31:0];
				default: begin
				end
			endcase
		end
	end

	// round sequencing
	always_ff @(posedge clk) begin
		if (rst) begin
			round_cnt <= '0;
			done <= 1'b0;
			swap <= 1'b0;
			round_start <= 1'b0;
			sr_resp_valid <= 1'b0;
		end else begin
			sr_resp_valid <= sr_valid && !sr_req.is_write;
			round_start <= 1'b0;
			if (start_wr) begin
				// round 1 always reads A and writes B
				round_cnt <= '0;
				swap <= 1'b0;
				done <= (n_rounds == 0);
				round_start <= (n_rounds != 0);
			end else if (round_done) begin
				round_cnt <= round_cnt + 32'd1;
				swap <= ~swap;
				if (round_cnt + 32'd1 < n_rounds)
					round_start <= 1'b1;
				else
					done <= 1'b1;
			end
		end
	end

	// read data one cycle after the request, unmapped reads as 0
	always_ff @(posedge clk) begin
		if (sr_valid && !sr_req.is_write) begin
			case (sr_req.addr)
				pr_pkg::reg_n_vert: sr_resp_data <= 64'(n_vert);
				pr_pkg::reg_n_inedges: sr_resp_data <= 64'(n_inedges);
				pr_pkg::reg_vert_base: sr_resp_data <= vert_base;
				pr_pkg::reg_ie_base: sr_resp_data <= ie_base;
				pr_pkg::reg_score_a: sr_resp_data <= score_a;
				pr_pkg::reg_score_b: sr_resp_data <= score_b;
				pr_pkg::reg_n_rounds: sr_resp_data <= 64'(n_rounds);
				pr_pkg::reg_round: sr_resp_data <= 64'(round_cnt);
				pr_pkg::reg_done: sr_resp_data <= 64'(done);
				default: sr_resp_data <= '0;
			endcase
		end
	end

	always_comb begin
		round_cfg.n_vert = n_vert;
		round_cfg.n_inedges = n_inedges;
		round_cfg.vert_base = vert_base;
		round_cfg.ie_base = ie_base;
		// buffers trade places every round
		round_cfg.rd_base = swap ? score_b : score_a;
		round_cfg.wr_base = swap ? score_a : score_b;
		round_cfg.first = (round_cnt == 0);
	end

endmodule

// File: source/pr_div.sv
module pr_div (
	input logic clk,
	input logic rst,
	input logic job_valid,
	input pr_pkg::div_job_t job,
	output logic job_ready,
	output logic res_valid,
	output pr_pkg::div_res_t res,
	input logic res_ready
);

	logic busy;
	logic [5:0] cnt;
	logic [63:0] quo;
	logic [31:0] rem;
	logic [31:0] dsr;
	logic zero;
	logic init_q;
	logic [32:0] trial;

	// trial subtract, borrow in the top bit means restore
	assign trial = {rem, quo[63]} - {1'b0, dsr};
	assign job_ready = !busy && !res_valid;
	assign res.quotient = zero ? '0 : quo;
	assign res.is_init = init_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			res_valid <= 1'b0;
			cnt <= '0;
		end else begin
			if (job_valid && job_ready) begin
				busy <= 1'b1;
				cnt <= '0;
			end else if (busy) begin
				cnt <= cnt + 6'd1;
				// last of 64 steps
				if (cnt == 6'(pr_pkg::word_w - 1)) begin
					busy <= 1'b0;
					res_valid <= 1'b1;
				end
			end
			if (res_valid && res_ready)
				res_valid <= 1'b0;
		end
	end

	// one quotient bit per cycle, msb first
	always_ff @(posedge clk) begin
		if (job_valid && job_ready) begin
			quo <= job.dividend;
			rem <= '0;
			dsr <= job.divisor;
			zero <= (job.divisor == 0);
			init_q <= job.is_init;
		end else if (busy) begin
			if (!trial[32]) begin
				rem <= trial[31:0];
				quo <= {quo[62:0], 1'b1};
			end else begin
				rem <= {rem[30:0], quo[63]};
				quo <= {quo[62:0], 1'b0};
			end
		end
	end

endmodule

// File: source/pr_fetch.sv
module pr_fetch (
	input logic clk,
	input logic rst,
	input pr_pkg::round_cfg_t round_cfg,
	input logic round_start,
	output logic ar_valid,
	output pr_pkg::mem_ar_t ar,
	input logic ar_ready,
	input logic r_valid,
	input pr_pkg::mem_r_t r,
	output logic r_ready,
	output logic vert_valid,
	output pr_pkg::vert_rec_t vert,
	input logic vert_ready,
	output logic score_valid,
	output logic [63:0] score,
	input logic score_ready
);

	logic [63:0] vert_q;
	logic [31:0] ie_q;
	logic vert_full;
	logic vert_empty;
	logic ie_full;
	logic ie_empty;
	logic score_full;
	logic score_empty;
	logic [31:0] vert_left;
	logic [31:0] ie_left;
	logic [63:0] vert_addr;
	logic [63:0] ie_addr;
	logic busy;
	logic want_score;
	logic want_ie;
	logic want_vert;
	logic issue;

	// each stream only asks when its FIFO has room for the response
	always_comb begin
		want_score = !ie_empty && !score_full;
		want_ie = (ie_left != 0) && !ie_full;
		want_vert = (vert_left != 0) && !vert_full;
		issue = !round_start && !ar_valid && !busy && (want_score || want_ie || want_vert);
	end

	assign r_ready = 1'b1;
	assign vert_valid = !vert_empty;
	assign vert = vert_q;
	assign score_valid = !score_empty;

	// request handshake and remaining-record counters
	always_ff @(posedge clk) begin
		if (rst) begin
			ar_valid <= 1'b0;
			busy <= 1'b0;
			vert_left <= '0;
			ie_left <= '0;
		end else begin
			if (round_start) begin
				vert_left <= round_cfg.n_vert;
				// round 1 sums the initial value, no edges needed
				ie_left <= round_cfg.first ? '0 : round_cfg.n_inedges;
			end else if (issue) begin
				ar_valid <= 1'b1;
				if (!want_score && want_ie)
					ie_left <= ie_left - 32'd1;
				else if (!want_score && !want_ie)
					vert_left <= vert_left - 32'd1;
			end
			if (ar_valid && ar_ready) begin
				ar_valid <= 1'b0;
				busy <= 1'b1;
			end
			if (r_valid)
				busy <= 1'b0;
		end
	end

	// addresses, fixed priority score > in-edge > vertex
	always_ff @(posedge clk) begin
		if (round_start) begin
			vert_addr <= round_cfg.vert_base;
			ie_addr <= round_cfg.ie_base;
		end else if (issue) begin
			if (want_score) begin
				ar.id <= pr_pkg::rid_score;
				ar.addr <= round_cfg.rd_base + 64'({ie_q, 3'b000});
			end else if (want_ie) begin
				ar.id <= pr_pkg::rid_inedge;
				ar.addr <= ie_addr;
				ie_addr <= ie_addr + 64'd8;
			end else begin
				ar.id <= pr_pkg::rid_vert;
				ar.addr <= vert_addr;
				vert_addr <= vert_addr + 64'd8;
			end
		end
	end

	pr_fifo #(
		.width(64),
		.depth(pr_pkg::fifo_depth)
	) i_vert_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(r_valid && (r.id == pr_pkg::rid_vert)),
		.wr_data(r.data.vert),
		.full(vert_full),
		.rd_en(vert_ready),
		.rd_data(vert_q),
		.empty(vert_empty)
	);

	// source index leaves the FIFO once its score read is latched
	pr_fifo #(
		.width(32),
		.depth(pr_pkg::fifo_depth)
	) i_ie_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(r_valid && (r.id == pr_pkg::rid_inedge)),
		.wr_data(r.data.raw[31:0]),
		.full(ie_full),
		.rd_en(issue && want_score),
		.rd_data(ie_q),
		.empty(ie_empty)
	);

	pr_fifo #(
		.width(64),
		.depth(pr_pkg::fifo_depth)
	) i_score_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(r_valid && (r.id == pr_pkg::rid_score)),
		.wr_data(r.data.raw),
		.full(score_full),
		.rd_en(score_ready),
		.rd_data(score),
		.empty(score_empty)
	);

endmodule

// File: source/pr_fifo.sv
module pr_fifo #(
	parameter int width = 64,
	parameter int depth = 16
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input logic [width-1:0] wr_data,
	output logic full,
	input logic rd_en,
	output logic [width-1:0] rd_data,
	output logic empty
);

	logic [width-1:0] mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic [$clog2(depth+1)-1:0] count;
	logic do_wr;
	logic do_rd;

	// writes when full and reads when empty are dropped
	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;
	assign full = (count == depth);
	assign empty = (count == 0);
	// head entry is always visible
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
			// count moves only when exactly one side is active
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

endmodule

// File: source/pr_pkg.sv
package pr_pkg;

	// bus and arithmetic widths
	localparam int word_w = 64;
	localparam int addr_w = 64;
	localparam int prec = 16;
	localparam int fifo_depth = 16;

	// read ids, used to route responses back to their stream
	localparam logic [1:0] rid_vert = 2'd0;
	localparam logic [1:0] rid_inedge = 2'd1;
	localparam logic [1:0] rid_score = 2'd2;

	// soft-register map
	localparam logic [31:0] reg_n_vert = 32'h00;
	localparam logic [31:0] reg_n_inedges = 32'h08;
	localparam logic [31:0] reg_vert_base = 32'h10;
	localparam logic [31:0] reg_ie_base = 32'h18;
	localparam logic [31:0] reg_score_a = 32'h20;
	localparam logic [31:0] reg_score_b = 32'h28;
	localparam logic [31:0] reg_n_rounds = 32'h30;
	localparam logic [31:0] reg_start = 32'h38;
	localparam logic [31:0] reg_round = 32'h40;
	localparam logic [31:0] reg_done = 32'h48;

	// accumulator FSM encoding
	localparam logic [2:0] acc_idle = 3'd0;
	localparam logic [2:0] acc_init_issue = 3'd1;
	localparam logic [2:0] acc_init_wait = 3'd2;
	localparam logic [2:0] acc_vert = 3'd3;
	localparam logic [2:0] acc_sum = 3'd4;
	localparam logic [2:0] acc_issue = 3'd5;

	typedef struct packed {
		logic [31:0] in_deg;
		logic [31:0] out_deg;
	} vert_rec_t;

	// one read word, seen as a vertex record or as a plain index/score
	typedef union packed {
		vert_rec_t vert;
		logic [word_w-1:0] raw;
	} mem_word_u;

	typedef struct packed {
		logic is_write;
		logic [31:0] addr;
		logic [63:0] data;
	} sr_req_t;

	typedef struct packed {
		logic [1:0] id;
		logic [addr_w-1:0] addr;
	} mem_ar_t;

	typedef struct packed {
		logic [1:0] id;
		mem_word_u data;
	} mem_r_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
	} mem_aw_t;

	typedef struct packed {
		logic [63:0] dividend;
		logic [31:0] divisor;
		logic is_init;
	} div_job_t;

	typedef struct packed {
		logic [63:0] quotient;
		logic is_init;
	} div_res_t;

	typedef struct packed {
		logic [31:0] n_vert;
		logic [31:0] n_inedges;
		logic [addr_w-1:0] vert_base;
		logic [addr_w-1:0] ie_base;
		logic [addr_w-1:0] rd_base;
		logic [addr_w-1:0] wr_base;
		logic first;
	} round_cfg_t;

endpackage

// File: source/pr_writeback.sv
module pr_writeback (
	input logic clk,
	input logic rst,
	input pr_pkg::round_cfg_t round_cfg,
	input logic round_start,
	input logic res_valid,
	input pr_pkg::div_res_t res,
	output logic res_ready,
	output logic aw_valid,
	output pr_pkg::mem_aw_t aw,
	input logic aw_ready,
	output logic w_valid,
	output logic [63:0] w_data,
	input logic w_ready,
	input logic b_valid,
	output logic b_ready,
	output logic round_done
);

	logic pend;
	logic [31:0] idx;
	logic take;

	// a stalled write keeps res_ready low, which holds the divider
	assign res_ready = !pend;
	assign b_ready = 1'b1;
	// init results are consumed here and dropped
	assign take = res_valid && res_ready && !res.is_init;

	always_ff @(posedge clk) begin
		if (rst) begin
			pend <= 1'b0;
			aw_valid <= 1'b0;
			w_valid <= 1'b0;
			round_done <= 1'b0;
			idx <= '0;
		end else begin
			round_done <= 1'b0;
			if (round_start)
				idx <= '0;
			// address and data go out together
			if (take) begin
				pend <= 1'b1;
				aw_valid <= 1'b1;
				w_valid <= 1'b1;
			end
			if (aw_valid && aw_ready)
				aw_valid <= 1'b0;
			if (w_valid && w_ready)
				w_valid <= 1'b0;
			// vertex counted on its write response
			if (pend && b_valid) begin
				pend <= 1'b0;
				if (idx + 32'd1 == round_cfg.n_vert) begin
					idx <= '0;
					round_done <= 1'b1;
				end else begin
					idx <= idx + 32'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			w_data <= res.quotient;
			aw.addr <= round_cfg.wr_base + 64'({idx, 3'b000});
		end
	end

endmodule
